//--- e300_lite_cfg.svh
/*
  register offsets are matched against address bits 10:0 only
  readback codes are 5 bits wide, unused codes return E300_RB_DEFAULT
*/
`ifndef E300_LITE_CFG_SVH
`define E300_LITE_CFG_SVH

// settings bus offsets
`define E300_SR_READBACK 11'd0
`define E300_SR_MISC     11'd4
`define E300_SR_SPP      11'd8
`define E300_SR_TEST     11'd28

// readback select codes
`define E300_RB_MISC     5'd1
`define E300_RB_COMPAT   5'd2
`define E300_RB_PLL      5'd4
`define E300_RB_ERR      5'd6
`define E300_RB_TEST     5'd24

`define E300_RB_DEFAULT  32'hdeadbeef
`define E300_COMPAT      32'hAC00_FF00

// misc bits 1:0 pps select, 2 mimo, 3 codec reset
`define E300_MISC_RESET  4'd2
`define E300_SPP_RESET   8'd4

`define E300_RX_DEPTH    8
`define E300_TX_DEPTH    4

`endif

//--- e300_lite_pkg.sv
/*
  shared data types for the single-radio core
  samples carry I in bits 31:16 and Q in bits 15:0
*/
package e300_lite_pkg;

  // one radio sample
  typedef logic [31:0] sample_t;

  // host stream word, two samples, earlier one low
  typedef logic [63:0] host_word_t;

  // readback selector
  typedef logic [4:0] rb_sel_t;

  // saturating error counter
  typedef logic [15:0] err_cnt_t;

endpackage

//--- stream_fifo.sv
/*
  valid/ready FIFO, no fall-through, a write shows at the output next cycle
  o_ready drops only when all DEPTH entries are in use
*/
`timescale 1ns/1ps

module stream_fifo #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 8
) (
  input  logic i_bus_clk,
  input  logic i_bus_rst,
  input  T     i_data,
  input  logic i_valid,
  output logic o_ready,
  output T     o_data,
  output logic o_valid,
  input  logic i_ready
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);
  localparam logic [AW-1:0] LAST_IDX = AW'(DEPTH - 1);

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;

  assign o_ready = (count != CW'(DEPTH));
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];

  assign push = i_valid && o_ready;
  assign pop  = o_valid && i_ready;

  // storage
  always_ff @(posedge i_bus_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // pointers wrap at DEPTH, not at a power of two
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- core_regs.sv
/*
  settings writes land on the strobe edge and read back the next cycle
  o_rb_data is combinational, lock inputs pass two flops before readback
*/
`timescale 1ns/1ps
`include "e300_lite_cfg.svh"

module core_regs (
  input  logic        i_bus_clk,
  input  logic        i_bus_rst,
  input  logic        i_set_stb,
  input  logic [31:0] i_set_addr,
  input  logic [31:0] i_set_data,
  input  logic [1:0]  i_lock_signals,
  input  logic [3:0]  i_tcxo_status,
  input  logic        i_rx_stb,
  input  logic        i_rx_room,
  input  logic        i_underrun,
  output logic [31:0] o_rb_data,
  output logic [1:0]  o_pps_select,
  output logic        o_mimo,
  output logic        o_codec_arst,
  output logic [7:0]  o_spp
);
  import e300_lite_pkg::*;

  rb_sel_t     rb_sel;
  logic [31:0] test_reg;
  logic [3:0]  misc_reg;
  logic [10:0] set_offset;
  logic [1:0]  lock_meta;
  logic [1:0]  lock_sync;
  err_cnt_t    overflow_cnt;
  err_cnt_t    underrun_cnt;

  assign set_offset = i_set_addr[10:0];

  ////////////////////
  // settings registers
  ////////////////////
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      rb_sel   <= '0;
      test_reg <= '0;
      misc_reg <= `E300_MISC_RESET;
      o_spp    <= `E300_SPP_RESET;
    end else if (i_set_stb) begin
      if (set_offset == `E300_SR_READBACK) rb_sel <= i_set_data[4:0];
      if (set_offset == `E300_SR_TEST) test_reg <= i_set_data;
      if (set_offset == `E300_SR_MISC) misc_reg <= i_set_data[3:0];
      if (set_offset == `E300_SR_SPP) o_spp <= i_set_data[7:0];
    end
  end

  assign o_pps_select = misc_reg[1:0];
  assign o_mimo       = misc_reg[2];
  assign o_codec_arst = misc_reg[3];

  // pll lock synchronizer
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      lock_meta <= '0;
      lock_sync <= '0;
    end else begin
      lock_meta <= i_lock_signals;
      lock_sync <= lock_meta;
    end
  end

  ////////////////////
  // error counters
  ////////////////////
  // both stick at full scale
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      overflow_cnt <= '0;
      underrun_cnt <= '0;
    end else begin
      if (i_rx_stb && !i_rx_room && (overflow_cnt != '1)) begin
        overflow_cnt <= overflow_cnt + 1'b1;
      end
      if (i_underrun && (underrun_cnt != '1)) begin
        underrun_cnt <= underrun_cnt + 1'b1;
      end
    end
  end

  // readback mux
  always_comb begin
    case (rb_sel)
      `E300_RB_MISC:   o_rb_data = {26'd0, i_tcxo_status, o_pps_select};
      `E300_RB_COMPAT: o_rb_data = `E300_COMPAT;
      `E300_RB_PLL:    o_rb_data = {30'd0, lock_sync};
      `E300_RB_ERR:    o_rb_data = {overflow_cnt, underrun_cnt};
      `E300_RB_TEST:   o_rb_data = test_reg;
      default:         o_rb_data = `E300_RB_DEFAULT;
    endcase
  end

endmodule

//--- rx_framer.sv
/*
  packs two samples per host word, earlier sample in bits 31:0
  i_spp is sampled at each packet start, 0 behaves as 1
*/
`timescale 1ns/1ps

module rx_framer (
  input  logic                    i_bus_clk,
  input  logic                    i_bus_rst,
  input  logic [7:0]              i_spp,
  input  e300_lite_pkg::sample_t  i_sample,
  input  logic                    i_sample_valid,
  output logic                    o_sample_ready,
  output e300_lite_pkg::host_word_t o_tdata,
  output logic                    o_tlast,
  output logic                    o_tvalid,
  input  logic                    i_tready
);
  import e300_lite_pkg::*;

  sample_t    low_q;
  logic       have_low;
  logic       pkt_start;
  logic [7:0] words_left;
  logic [7:0] words_now;
  logic       last_now;
  logic       take;

  // second half only goes in when the output slot frees up
  assign o_sample_ready = !have_low || !o_tvalid || i_tready;
  assign take = i_sample_valid && o_sample_ready;

  assign words_now = pkt_start ? i_spp : words_left;
  assign last_now  = (words_now <= 8'd1);

  // half holding register and word payload
  always_ff @(posedge i_bus_clk) begin
    if (take && !have_low) low_q <= i_sample;
    if (take && have_low) begin
      o_tdata <= {i_sample, low_q};
      o_tlast <= last_now;
    end
  end

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      have_low   <= 1'b0;
      o_tvalid   <= 1'b0;
      pkt_start  <= 1'b1;
      words_left <= '0;
    end else begin
      if (o_tvalid && i_tready) o_tvalid <= 1'b0;
      if (take) have_low <= !have_low;
      if (take && have_low) begin
        o_tvalid   <= 1'b1;
        pkt_start  <= last_now;
        words_left <= words_now - 1'b1;
      end
    end
  end

endmodule

//--- tx_unframer.sv
/*
  one sample out per i_tx_stb, low half of each word first
  a strobe with nothing stored drives zero and pulses o_underrun
*/
`timescale 1ns/1ps

module tx_unframer (
  input  logic                      i_bus_clk,
  input  logic                      i_bus_rst,
  input  e300_lite_pkg::host_word_t i_word,
  input  logic                      i_word_valid,
  output logic                      o_word_ready,
  input  logic                      i_tx_stb,
  output e300_lite_pkg::sample_t    o_tx_data,
  output logic                      o_underrun
);
  import e300_lite_pkg::*;

  host_word_t word_q;
  logic       full;
  logic       hi_next;
  logic       load;

  // refill once the high half goes out
  assign o_word_ready = !full || (i_tx_stb && hi_next);
  assign load = i_word_valid && o_word_ready;

  always_ff @(posedge i_bus_clk) begin
    if (load) word_q <= i_word;
  end

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      full       <= 1'b0;
      hi_next    <= 1'b0;
      o_tx_data  <= '0;
      o_underrun <= 1'b0;
    end else begin
      o_underrun <= i_tx_stb && !full;
      if (i_tx_stb) begin
        if (full) begin
          o_tx_data <= hi_next ? word_q[63:32] : word_q[31:0];
          hi_next   <= !hi_next;
          if (hi_next) full <= 1'b0;
        end else begin
          o_tx_data <= '0;
        end
      end
      // a new word overrides the consume above
      if (load) begin
        full    <= 1'b1;
        hi_next <= 1'b0;
      end
    end
  end

endmodule

//--- e300_lite_core.sv
/*
  single radio, single clock domain, host tlast is not used on transmit
  receive samples are dropped and counted while the receive FIFO is full
*/
`timescale 1ns/1ps
`include "e300_lite_cfg.svh"

module e300_lite_core (
  input  logic                      i_bus_clk,
  input  logic                      i_bus_rst,
  // host to radio stream
  input  e300_lite_pkg::host_word_t i_h2s_tdata,
  input  logic                      i_h2s_tvalid,
  output logic                      o_h2s_tready,
  // radio to host stream
  output e300_lite_pkg::host_word_t o_s2h_tdata,
  output logic                      o_s2h_tlast,
  output logic                      o_s2h_tvalid,
  input  logic                      i_s2h_tready,
  // radio side
  input  logic                      i_rx_stb,
  input  e300_lite_pkg::sample_t    i_rx_data,
  input  logic                      i_tx_stb,
  output e300_lite_pkg::sample_t    o_tx_data,
  // settings bus
  input  logic                      i_set_stb,
  input  logic [31:0]               i_set_addr,
  input  logic [31:0]               i_set_data,
  output logic [31:0]               o_rb_data,
  output logic [1:0]                o_pps_select,
  output logic                      o_mimo,
  output logic                      o_codec_arst,
  input  logic [1:0]                i_lock_signals,
  input  logic [3:0]                i_tcxo_status
);
  import e300_lite_pkg::*;

  logic       rx_room;
  sample_t    rx_sample;
  logic       rx_sample_valid;
  logic       rx_sample_ready;
  host_word_t tx_word;
  logic       tx_word_valid;
  logic       tx_word_ready;
  logic       underrun;
  logic [7:0] spp;

  core_regs u_core_regs (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_lock_signals(i_lock_signals), .i_tcxo_status(i_tcxo_status),
    .i_rx_stb(i_rx_stb), .i_rx_room(rx_room), .i_underrun(underrun),
    .o_rb_data(o_rb_data), .o_pps_select(o_pps_select), .o_mimo(o_mimo),
    .o_codec_arst(o_codec_arst), .o_spp(spp)
  );

  ////////////////////
  // receive path
  ////////////////////
  stream_fifo #(.T(sample_t), .DEPTH(`E300_RX_DEPTH)) u_rx_fifo (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst),
    .i_data(i_rx_data), .i_valid(i_rx_stb), .o_ready(rx_room),
    .o_data(rx_sample), .o_valid(rx_sample_valid), .i_ready(rx_sample_ready)
  );

  rx_framer u_rx_framer (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .i_spp(spp),
    .i_sample(rx_sample), .i_sample_valid(rx_sample_valid),
    .o_sample_ready(rx_sample_ready),
    .o_tdata(o_s2h_tdata), .o_tlast(o_s2h_tlast),
    .o_tvalid(o_s2h_tvalid), .i_tready(i_s2h_tready)
  );

  ////////////////////
  // transmit path
  ////////////////////
  stream_fifo #(.T(host_word_t), .DEPTH(`E300_TX_DEPTH)) u_tx_fifo (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst),
    .i_data(i_h2s_tdata), .i_valid(i_h2s_tvalid), .o_ready(o_h2s_tready),
    .o_data(tx_word), .o_valid(tx_word_valid), .i_ready(tx_word_ready)
  );

  tx_unframer u_tx_unframer (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst),
    .i_word(tx_word), .i_word_valid(tx_word_valid), .o_word_ready(tx_word_ready),
    .i_tx_stb(i_tx_stb), .o_tx_data(o_tx_data), .o_underrun(underrun)
  );

endmodule

//--- e300_lite_chk.sv
/*
  bound to e300_lite_core, watches the s2h handshake and the transmit FIFO
  FIFO level is rebuilt here from the push and pop handshakes
*/
`timescale 1ns/1ps
`include "e300_lite_cfg.svh"

module e300_lite_chk (
  input logic                      i_bus_clk,
  input logic                      i_bus_rst,
  input e300_lite_pkg::host_word_t i_s2h_tdata,
  input logic                      i_s2h_tlast,
  input logic                      i_s2h_tvalid,
  input logic                      i_s2h_tready,
  input logic                      i_h2s_tvalid,
  input logic                      i_h2s_tready,
  input logic                      i_tx_pop_valid,
  input logic                      i_tx_pop_ready
);

  logic [3:0] tx_level;
  logic       tx_push;
  logic       tx_pop;

  // assertion failures seen so far
  int         fail_count;

  assign tx_push = i_h2s_tvalid && i_h2s_tready;
  assign tx_pop  = i_tx_pop_valid && i_tx_pop_ready;

  // shadow of the transmit FIFO occupancy
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      tx_level <= '0;
    end else begin
      case ({tx_push, tx_pop})
        2'b10:   tx_level <= tx_level + 4'd1;
        2'b01:   tx_level <= tx_level - 4'd1;
        default: tx_level <= tx_level;
      endcase
    end
  end

  a_s2h_stable: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
    (i_s2h_tvalid && !i_s2h_tready) |=> ($stable(i_s2h_tdata) && $stable(i_s2h_tlast)))
    else begin
      $error("s2h data or tlast changed while the word was stalled");
      fail_count++;
    end

  a_s2h_reset: assert property (@(posedge i_bus_clk) i_bus_rst |=> !i_s2h_tvalid)
    else begin
      $error("s2h valid is high right after reset");
      fail_count++;
    end

  a_h2s_full: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
    (tx_level == 4'(`E300_TX_DEPTH)) |-> !i_h2s_tready)
    else begin
      $error("h2s ready is high while the transmit FIFO is full");
      fail_count++;
    end

endmodule

bind e300_lite_core e300_lite_chk u_chk (
  .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst),
  .i_s2h_tdata(o_s2h_tdata), .i_s2h_tlast(o_s2h_tlast),
  .i_s2h_tvalid(o_s2h_tvalid), .i_s2h_tready(i_s2h_tready),
  .i_h2s_tvalid(i_h2s_tvalid), .i_h2s_tready(o_h2s_tready),
  .i_tx_pop_valid(tx_word_valid), .i_tx_pop_ready(tx_word_ready)
);

//--- e300_lite_tb.sv
/*
  directed tests for e300_lite_core, inputs change on the falling edge
  outputs are sampled on the falling edge where they are stable
*/
`timescale 1ns/1ps
`include "e300_lite_cfg.svh"

module e300_lite_tb;
  import e300_lite_pkg::*;

  localparam int BUDGET_REGS = 40;
  localparam int BUDGET_PLL  = 20;
  localparam int BUDGET_RX   = 60;
  localparam int BUDGET_TX   = 40;
  localparam int BUDGET_OVF  = 120;
  localparam int WATCHDOG_CYCLES =
    2 * (BUDGET_REGS + BUDGET_PLL + BUDGET_RX + BUDGET_TX + BUDGET_OVF);

  // s2h counts as drained after this many cycles with no word
  localparam int QUIET_CYCLES = 8;

  logic        bus_clk;
  logic        bus_rst;
  host_word_t  h2s_tdata;
  logic        h2s_tvalid;
  logic        h2s_tready;
  host_word_t  s2h_tdata;
  logic        s2h_tlast;
  logic        s2h_tvalid;
  logic        s2h_tready;
  logic        rx_stb;
  sample_t     rx_data;
  logic        tx_stb;
  sample_t     tx_data;
  logic        set_stb;
  logic [31:0] set_addr;
  logic [31:0] set_data;
  logic [31:0] rb_data;
  logic [1:0]  pps_select;
  logic        mimo;
  logic        codec_arst;
  logic [1:0]  lock_signals;
  logic [3:0]  tcxo_status;

  integer      seed;
  int          err_value;
  int          err_other;
  sample_t     sent_q[$];
  host_word_t  got_words[$];
  logic        got_lasts[$];

  e300_lite_core dut (
    .i_bus_clk(bus_clk), .i_bus_rst(bus_rst),
    .i_h2s_tdata(h2s_tdata), .i_h2s_tvalid(h2s_tvalid), .o_h2s_tready(h2s_tready),
    .o_s2h_tdata(s2h_tdata), .o_s2h_tlast(s2h_tlast),
    .o_s2h_tvalid(s2h_tvalid), .i_s2h_tready(s2h_tready),
    .i_rx_stb(rx_stb), .i_rx_data(rx_data), .i_tx_stb(tx_stb), .o_tx_data(tx_data),
    .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
    .o_rb_data(rb_data), .o_pps_select(pps_select), .o_mimo(mimo),
    .o_codec_arst(codec_arst), .i_lock_signals(lock_signals), .i_tcxo_status(tcxo_status)
  );

  always #5 bus_clk = ~bus_clk;

  //////////////////////
  // compare tasks
  //////////////////////
  task automatic check_rb(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      err_value++;
    end
  endtask

  task automatic check_word(input string name, input host_word_t exp, input logic exp_last,
                            input host_word_t act, input logic act_last);
    if (act !== exp || act_last !== exp_last) begin
      $display("[FAIL] %s: expected %h last %b, actual %h last %b",
               name, exp, exp_last, act, act_last);
      err_value++;
    end
  endtask

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      err_value++;
    end
  endtask

  task automatic report_other(input string msg);
    $display("[ERROR] %s", msg);
    err_other++;
  endtask

  //////////////////////
  // bus drivers
  //////////////////////
  // every driver is entered and left on a falling edge
  task automatic set_write(input logic [10:0] offset, input logic [31:0] data);
    set_addr = {21'd0, offset};
    set_data = data;
    set_stb  = 1'b1;
    @(negedge bus_clk);
    set_stb  = 1'b0;
  endtask

  task automatic select_rb(input rb_sel_t code);
    set_write(`E300_SR_READBACK, {27'd0, code});
  endtask

  task automatic rx_strobes(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      rx_data = $random(seed);
      sent_q.push_back(rx_data);
      rx_stb = 1'b1;
      @(negedge bus_clk);
    end
    rx_stb = 1'b0;
  endtask

  // a word seen with valid and ready here moves on the next rising edge
  task automatic collect_words(input int n, input int budget);
    int waited;
    waited = 0;
    while (got_words.size() < n && waited < budget) begin
      if (s2h_tvalid && s2h_tready) begin
        got_words.push_back(s2h_tdata);
        got_lasts.push_back(s2h_tlast);
      end
      @(negedge bus_clk);
      waited++;
    end
    if (got_words.size() < n) report_other("timed out waiting for words on the s2h stream");
  endtask

  // takes every s2h word until the stream stays quiet
  task automatic drain_words(input int budget);
    int waited;
    int quiet;
    waited = 0;
    quiet  = 0;
    while (quiet < QUIET_CYCLES && waited < budget) begin
      if (s2h_tvalid && s2h_tready) begin
        got_words.push_back(s2h_tdata);
        got_lasts.push_back(s2h_tlast);
        quiet = 0;
      end else begin
        quiet++;
      end
      @(negedge bus_clk);
      waited++;
    end
    if (quiet < QUIET_CYCLES) report_other("s2h stream never went quiet");
  endtask

  task automatic send_host_word(input host_word_t w);
    int waited;
    waited = 0;
    h2s_tdata  = w;
    h2s_tvalid = 1'b1;
    while (!h2s_tready && waited < BUDGET_TX) begin
      @(negedge bus_clk);
      waited++;
    end
    if (!h2s_tready) report_other("h2s ready never came up for a host word");
    @(negedge bus_clk);
    h2s_tvalid = 1'b0;
  endtask

  task automatic tx_strobe(output sample_t got);
    tx_stb = 1'b1;
    @(negedge bus_clk);
    tx_stb = 1'b0;
    got = tx_data;
  endtask

  //////////////////////
  // tests
  //////////////////////
  task automatic test_reset_regs();
    check_rb("pps_select after reset", 32'd2, {30'd0, pps_select});
    check_rb("mimo and codec_arst after reset", 32'd0, {30'd0, codec_arst, mimo});
    select_rb(`E300_RB_COMPAT);
    check_rb("compat readback", `E300_COMPAT, rb_data);
    select_rb(5'd31);
    check_rb("unused readback code", `E300_RB_DEFAULT, rb_data);
    set_write(`E300_SR_TEST, 32'h5a3c_9617);
    select_rb(`E300_RB_TEST);
    check_rb("test register readback", 32'h5a3c_9617, rb_data);
    // 4'b1101 sets pps 1, mimo and codec reset
    set_write(`E300_SR_MISC, 32'h0000_000d);
    check_rb("pps_select after misc write", 32'd1, {30'd0, pps_select});
    check_rb("mimo and codec_arst after misc write", 32'd3, {30'd0, codec_arst, mimo});
    select_rb(`E300_RB_MISC);
    check_rb("misc readback", {26'd0, 4'ha, 2'b01}, rb_data);
    set_write(`E300_SR_MISC, 32'd2);
  endtask

  task automatic test_pll_lock();
    lock_signals = 2'b10;
    repeat (3) @(negedge bus_clk);
    select_rb(`E300_RB_PLL);
    check_rb("pll lock 2'b10", 32'd2, rb_data);
    lock_signals = 2'b01;
    repeat (3) @(negedge bus_clk);
    check_rb("pll lock 2'b01", 32'd1, rb_data);
  endtask

  task automatic test_rx_framing();
    int k;
    set_write(`E300_SR_SPP, 32'd3);
    s2h_tready = 1'b1;
    sent_q.delete();
    got_words.delete();
    got_lasts.delete();
    fork
      rx_strobes(12);
      collect_words(6, BUDGET_RX);
    join
    for (k = 0; k < got_words.size(); k++) begin
      check_word($sformatf("rx word %0d", k), {sent_q[2*k+1], sent_q[2*k]},
                 (k % 3) == 2, got_words[k], got_lasts[k]);
    end
  endtask

  task automatic test_tx_unpack();
    host_word_t words[2];
    sample_t    got;
    int         k;
    int         taken;
    words[0] = {$random(seed), $random(seed)};
    words[1] = {$random(seed), $random(seed)};
    send_host_word(words[0]);
    send_host_word(words[1]);
    for (k = 0; k < 4; k++) begin
      tx_strobe(got);
      check_sample($sformatf("tx sample %0d", k),
                   (k % 2 == 1) ? words[k/2][63:32] : words[k/2][31:0], got);
    end
    tx_strobe(got);
    check_sample("tx sample on underrun", '0, got);
    select_rb(`E300_RB_ERR);
    check_rb("error counters after underrun", {16'd0, 16'd1}, rb_data);
    // offer words with no strobes until the transmit side backs up
    taken      = 0;
    h2s_tvalid = 1'b1;
    while (h2s_tready && taken < 2 * `E300_TX_DEPTH) begin
      h2s_tdata = {$random(seed), $random(seed)};
      @(negedge bus_clk);
      taken++;
    end
    h2s_tvalid = 1'b0;
    // the unframer holds one word on top of a full FIFO
    check_rb("h2s words taken before back-pressure", `E300_TX_DEPTH + 1, taken);
  endtask

  task automatic test_rx_overflow();
    int k;
    int ovf;
    int accepted;
    int hi_idx;
    int delivered;
    s2h_tready = 1'b0;
    sent_q.delete();
    got_words.delete();
    got_lasts.delete();
    rx_strobes(30);
    select_rb(`E300_RB_ERR);
    ovf = int'(rb_data[31:16]);
    if (ovf == 0) report_other("no overflow counted while s2h was held off");
    accepted = (ovf > 30) ? 0 : 30 - ovf;
    s2h_tready = 1'b1;
    drain_words(BUDGET_OVF);
    // an odd sample waits in the framer for a partner
    if (accepted % 2 == 1) begin
      rx_strobes(1);
      drain_words(BUDGET_OVF);
    end
    delivered = 0;
    for (k = 0; k < got_words.size(); k++) begin
      hi_idx = (2 * k + 1 < accepted) ? 2 * k + 1 : 30;
      check_word($sformatf("overflow word %0d", k), {sent_q[hi_idx], sent_q[2*k]},
                 (k % 3) == 2, got_words[k], got_lasts[k]);
      delivered += (hi_idx == 30) ? 1 : 2;
    end
    check_rb("delivered plus dropped samples", 32'd30, 32'(delivered + ovf));
  endtask

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("watchdog expired before the tests finished");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    seed         = 32'hf49a_6fd0;
    err_value    = 0;
    err_other    = 0;
    bus_clk      = 1'b0;
    bus_rst      = 1'b1;
    h2s_tdata    = '0;
    h2s_tvalid   = 1'b0;
    s2h_tready   = 1'b0;
    rx_stb       = 1'b0;
    rx_data      = '0;
    tx_stb       = 1'b0;
    set_stb      = 1'b0;
    set_addr     = '0;
    set_data     = '0;
    lock_signals = 2'b00;
    tcxo_status  = 4'ha;
    repeat (4) @(posedge bus_clk);
    @(negedge bus_clk);
    bus_rst = 1'b0;
    test_reset_regs();
    test_pll_lock();
    test_rx_framing();
    test_tx_unpack();
    test_rx_overflow();
    $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
             err_value, err_other, dut.u_chk.fail_count);
    if (err_value == 0 && err_other == 0 && dut.u_chk.fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- e300_lite.f
+incdir+.
e300_lite_pkg.sv
stream_fifo.sv
core_regs.sv
rx_framer.sv
tx_unframer.sv
e300_lite_core.sv
e300_lite_chk.sv
e300_lite_tb.sv

//--- Makefile
TOP = e300_lite_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f e300_lite.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f e300_lite.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Done: errors found" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
